/* flist.f */
tag_boot_pkg.sv
tag_trace_rom.sv
replay_timer.sv
tag_replay_fsm.sv
tag_frame_shifter.sv
tag_client_bank.sv
tag_boot_top.sv
tb_tag_boot.sv

/* Makefile */
# Verilator build and run for the tag boot testbench

VERILATOR ?= verilator
TOP       ?= tb_tag_boot
FLIST     ?= flist.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
JOBS      ?= 0
VFLAGS    ?= --binary --timing --assert -j $(JOBS)

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FLIST) --Mdir $(BUILD_DIR)

run: compile
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	@if grep -q "Verification failed" $(LOG); then \
		echo "Simulation reported failure"; \
		exit 1; \
	fi
	@if ! grep -q "Verification passed" $(LOG); then \
		echo "Simulation ended without a pass result"; \
		exit 1; \
	fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)

/* tb_tag_boot.sv */
/*
 * Testbench for the tag boot top, random traces replayed against a model,
 * checks on done timing, core reset release and client register values
 */

`timescale 1ns/10ps

module tb_tag_boot;

  import tag_boot_pkg::*;

  localparam int          CLK_HALF     = 2;
  localparam int          CLK_PERIOD   = 2 * CLK_HALF;
  localparam int          RESET_CYCLES = 8;
  localparam int unsigned SEED         = 32'h54644c74;
  localparam int          NUM_RANDOM   = 4;
  localparam int          NUM_TRACE_TESTS = NUM_RANDOM + 4;
  localparam int          MODE_NORMAL  = 0;
  localparam int          MODE_EARLY   = 1;
  localparam int          MODE_WRAP    = 2;

  // Longest wait entry is 2 + 16 cycles, plus trace load and start
  localparam int WORST_CYCLES = TRACE_DEPTH * 18 + RESET_DEPTH + TRACE_DEPTH + 12;
  localparam int WATCHDOG_NS  = (NUM_TRACE_TESTS + 1) * WORST_CYCLES * CLK_PERIOD * 2;

  logic                       clk = 1'b0;
  logic                       arst_n;
  logic                       start;
  logic                       trace_we;
  trace_addr_t                trace_waddr;
  trace_entry_t               trace_wdata;
  logic                       tag_done;
  logic                       core_reset;
  payload_t [NUM_CLIENTS-1:0] client_data;

  trace_entry_t               trace_q [TRACE_DEPTH];
  payload_t [NUM_CLIENTS-1:0] exp_client;
  int                         err_cnt;
  int                         tests_run;
  int                         tests_failed;

  always #(CLK_HALF) clk = ~clk;

  tag_boot_top tag_boot_top_inst (
    .clk_i(clk)
    ,.arst_n_i(arst_n)
    ,.start_i(start)
    ,.trace_we_i(trace_we)
    ,.trace_waddr_i(trace_waddr)
    ,.trace_wdata_i(trace_wdata)
    ,.tag_done_o(tag_done)
    ,.core_reset_o(core_reset)
    ,.client_data_o(client_data)
  );

  //--------------------------------------------------
  // Helpers
  //--------------------------------------------------
  task automatic expect_true(input bit ok, input string msg);
    assert (ok) else begin
      $display("FAILED at %0t ns: %s", $time, msg);
      err_cnt++;
    end
  endtask

  task automatic report_test(input string name, input int errs_before);
    tests_run++;
    if (err_cnt != errs_before) begin
      tests_failed++;
    end
    $display("test %0d (%s): %s", tests_run, name, (err_cnt == errs_before) ? "pass" : "fail");
  endtask

  // One finish at a random spot, early finish or rsvd, or none for the wrap case
  task automatic make_trace(input int mode);
    int                  pos;
    logic [OPCODE_W-1:0] op;
    client_id_t          id;
    payload_t            pl;
    pos = (mode == MODE_EARLY) ? int'($urandom_range(0, 3))
                               : int'($urandom_range(0, TRACE_DEPTH - 1));
    for (int i = 0; i < TRACE_DEPTH; i++) begin
      op = OPCODE_W'($urandom_range(0, 1));
      id = client_id_t'($urandom());
      pl = payload_t'($urandom());
      if (op == OP_WAIT) begin
        pl = payload_t'(pl[3:0]);
      end
      if (mode != MODE_WRAP && i == pos) begin
        op = (mode == MODE_EARLY && $urandom_range(0, 1) == 1) ? OP_RSVD : OP_FINISH;
      end
      trace_q[i] = {op, id, pl};
    end
  endtask

  task automatic load_trace();
    for (int i = 0; i < TRACE_DEPTH; i++) begin
      @(posedge clk);
      trace_we    <= 1'b1;
      trace_waddr <= trace_addr_t'(i);
      trace_wdata <= trace_q[i];
    end
    @(posedge clk);
    trace_we <= 1'b0;
  endtask

  // Cycles from start accepted to done, client values updated in place
  task automatic model_replay(output int cycles);
    logic [OPCODE_W-1:0] op;
    client_id_t          id;
    payload_t            pl;
    bit                  stop;
    cycles = 0;
    stop   = 1'b0;
    for (int i = 0; i < TRACE_DEPTH && !stop; i++) begin
      op = trace_q[i][TRACE_ENTRY_W-1 -: OPCODE_W];
      id = trace_q[i][PAYLOAD_W +: CLIENT_ID_W];
      pl = trace_q[i][PAYLOAD_W-1:0];
      cycles += 2;
      if (op == OP_SEND) begin
        cycles += FRAME_LEN;
        exp_client[id] = pl;
      end else if (op == OP_WAIT) begin
        cycles += int'(pl) + 1;
      end else begin
        stop = 1'b1;
      end
    end
    cycles += RESET_DEPTH;
  endtask

  //--------------------------------------------------
  // Replay of the trace in memory
  //--------------------------------------------------
  task automatic run_replay(input string name, input bit junk_writes);
    int errs_before;
    int t_exp;
    int k;
    bit seen;
    errs_before = err_cnt;
    model_replay(t_exp);
    @(posedge clk);
    start <= 1'b1;
    @(posedge clk);
    start <= 1'b0;
    k    = 0;
    seen = 1'b0;
    while (!seen && k <= t_exp + 8) begin
      @(negedge clk);
      if (tag_done) begin
        seen = 1'b1;
      end else begin
        expect_true(core_reset === 1'b1,
                    $sformatf("core_reset_o low at cycle %0d before done", k));
        k++;
        @(posedge clk);
        // Junk writes issued while the FSM is busy
        if (junk_writes && k < t_exp - 1) begin
          trace_we    <= 1'b1;
          trace_waddr <= trace_addr_t'($urandom());
          trace_wdata <= trace_entry_t'($urandom());
        end else begin
          trace_we <= 1'b0;
        end
      end
    end
    if (!seen) begin
      $display("ERROR: tag_done_o never rose during test '%s'", name);
      err_cnt++;
    end else begin
      expect_true(k == t_exp, $sformatf("done at cycle %0d, expected %0d", k, t_exp));
      expect_true(core_reset === 1'b0, "core_reset_o still high at done");
      expect_true(client_data === exp_client,
                  $sformatf("clients %h, expected %h", client_data, exp_client));
    end
    @(posedge clk);
    trace_we <= 1'b0;
    report_test(name, errs_before);
  endtask

  task automatic check_reset_state();
    int errs_before;
    errs_before = err_cnt;
    repeat (10) begin
      @(negedge clk);
      expect_true(core_reset === 1'b1, "core_reset_o not high after reset");
      expect_true(tag_done === 1'b0, "tag_done_o not low after reset");
      expect_true(client_data === '0, $sformatf("clients %h after reset", client_data));
    end
    report_test("reset state", errs_before);
  endtask

  //--------------------------------------------------
  // Main sequence
  //--------------------------------------------------
  initial begin
    void'($urandom(SEED));
    err_cnt      = 0;
    tests_run    = 0;
    tests_failed = 0;
    exp_client   = '0;
    arst_n       = 1'b0;
    start        = 1'b0;
    trace_we     = 1'b0;
    trace_waddr  = '0;
    trace_wdata  = '0;
    repeat (RESET_CYCLES) @(posedge clk);
    arst_n <= 1'b1;

    check_reset_state();
    for (int t = 0; t < NUM_RANDOM; t++) begin
      make_trace(MODE_NORMAL);
      load_trace();
      run_replay("random trace", 1'b0);
    end
    make_trace(MODE_EARLY);
    load_trace();
    run_replay("early finish or reserved", 1'b0);
    make_trace(MODE_WRAP);
    load_trace();
    run_replay("no finish, ends after entry 15", 1'b0);
    // Same trace again, memory must be untouched by the busy writes
    run_replay("restart from done with writes while busy", 1'b1);
    make_trace(MODE_NORMAL);
    load_trace();
    run_replay("reload after done", 1'b0);

    $display("Summary: %0d tests, %0d failed, %0d check errors",
             tests_run, tests_failed, err_cnt);
    if (err_cnt == 0) begin
      $display("Verification passed");
    end else begin
      $display("Verification failed");
    end
    $finish;
  end

  initial begin
    #(WATCHDOG_NS);
    $display("ERROR: watchdog expired, the run took longer than all tests should need");
    $display("Verification failed");
    $finish;
  end

endmodule

/* tag_boot_top.sv */
/*
 * Tag boot top, trace memory, replay FSM, timer, frame shifter and client bank
 */

`timescale 1ns/10ps

module tag_boot_top (
  input  logic                                               clk_i
  , input  logic                                             arst_n_i
  , input  logic                                             start_i
  , input  logic                                             trace_we_i
  , input  tag_boot_pkg::trace_addr_t                        trace_waddr_i
  , input  tag_boot_pkg::trace_entry_t                       trace_wdata_i
  , output logic                                             tag_done_o
  , output logic                                             core_reset_o
  , output tag_boot_pkg::payload_t [tag_boot_pkg::NUM_CLIENTS-1:0] client_data_o
);

  import tag_boot_pkg::*;

  trace_addr_t  rd_addr;
  trace_entry_t rd_entry;
  logic         trace_we;
  logic         busy;
  logic         timer_load;
  timer_t       timer_count;
  logic         timer_zero;
  logic         frame_load;
  client_id_t   frame_id;
  payload_t     frame_payload;
  logic         tag_line;

  // No trace writes during a replay
  assign trace_we = trace_we_i & ~busy;

  tag_trace_rom trace_rom_inst (
    .clk_i(clk_i)
    ,.we_i(trace_we)
    ,.waddr_i(trace_waddr_i)
    ,.wdata_i(trace_wdata_i)
    ,.raddr_i(rd_addr)
    ,.rdata_o(rd_entry)
  );

  tag_replay_fsm replay_fsm_inst (
    .clk_i(clk_i)
    ,.arst_n_i(arst_n_i)
    ,.start_i(start_i)
    ,.entry_i(rd_entry)
    ,.timer_zero_i(timer_zero)
    ,.rd_addr_o(rd_addr)
    ,.timer_load_o(timer_load)
    ,.timer_count_o(timer_count)
    ,.frame_load_o(frame_load)
    ,.frame_id_o(frame_id)
    ,.frame_payload_o(frame_payload)
    ,.busy_o(busy)
    ,.tag_done_o(tag_done_o)
    ,.core_reset_o(core_reset_o)
  );

  replay_timer replay_timer_inst (
    .clk_i(clk_i)
    ,.arst_n_i(arst_n_i)
    ,.load_i(timer_load)
    ,.count_i(timer_count)
    ,.zero_o(timer_zero)
  );

  //--------------------------------------------------
  // Serial tag path
  //--------------------------------------------------
  tag_frame_shifter frame_shifter_inst (
    .clk_i(clk_i)
    ,.arst_n_i(arst_n_i)
    ,.load_i(frame_load)
    ,.id_i(frame_id)
    ,.payload_i(frame_payload)
    ,.tag_line_o(tag_line)
  );

  tag_client_bank client_bank_inst (
    .clk_i(clk_i)
    ,.arst_n_i(arst_n_i)
    ,.tag_line_i(tag_line)
    ,.client_data_o(client_data_o)
  );

endmodule

/* tag_client_bank.sv */
/*
 * Tag client bank, deserializes frames from the tag line
 * and loads the addressed configuration register
 */

`timescale 1ns/10ps

module tag_client_bank (
  input  logic                                               clk_i
  , input  logic                                             arst_n_i
  , input  logic                                             tag_line_i
  , output tag_boot_pkg::payload_t [tag_boot_pkg::NUM_CLIENTS-1:0] client_data_o
);

  import tag_boot_pkg::*;

  logic                             active_q;
  logic [BIT_CNT_W-1:0]             bit_cnt_q;
  logic [CLIENT_ID_W+PAYLOAD_W-2:0] shift_q;
  logic [CLIENT_ID_W+PAYLOAD_W-1:0] frame;
  logic                             last_bit;
  client_id_t                       frame_id;
  payload_t [NUM_CLIENTS-1:0]       client_q;

  // Bits collected so far plus the one on the line now
  assign frame    = {shift_q, tag_line_i};
  assign frame_id = frame[PAYLOAD_W +: CLIENT_ID_W];
  assign last_bit = active_q && (bit_cnt_q == BIT_CNT_W'(FRAME_LEN - 2));

  //--------------------------------------------------
  // Start detect and bit count
  //--------------------------------------------------
  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      active_q  <= 1'b0;
      bit_cnt_q <= '0;
    end else if (!active_q) begin
      if (tag_line_i) begin
        active_q  <= 1'b1;
        bit_cnt_q <= '0;
      end
    end else begin
      bit_cnt_q <= bit_cnt_q + BIT_CNT_W'(1);
      if (last_bit) begin
        active_q <= 1'b0;
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (active_q) begin
      shift_q <= frame[CLIENT_ID_W+PAYLOAD_W-2:0];
    end
  end

  // Client registers
  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      client_q <= '0;
    end else if (last_bit) begin
      client_q[frame_id] <= frame[PAYLOAD_W-1:0];
    end
  end

  assign client_data_o = client_q;

endmodule

/* tag_frame_shifter.sv */
/*
 * Tag frame serializer, start bit then id then payload, MSB first
 */

`timescale 1ns/10ps

module tag_frame_shifter (
  input  logic                     clk_i
  , input  logic                   arst_n_i
  , input  logic                   load_i
  , input  tag_boot_pkg::client_id_t id_i
  , input  tag_boot_pkg::payload_t   payload_i
  , output logic                   tag_line_o
);

  import tag_boot_pkg::*;

  logic [FRAME_LEN-1:0] frame_q;

  // Zeros shift in behind the frame so the line idles low
  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      frame_q <= '0;
    end else if (load_i) begin
      frame_q <= {1'b1, id_i, payload_i};
    end else begin
      frame_q <= {frame_q[FRAME_LEN-2:0], 1'b0};
    end
  end

  assign tag_line_o = frame_q[FRAME_LEN-1];

endmodule

/* tag_replay_fsm.sv */
/*
 * Trace replay FSM, steps through send, wait and finish entries
 * and holds core reset until the release interval ends
 */

`timescale 1ns/10ps

module tag_replay_fsm (
  input  logic                       clk_i
  , input  logic                     arst_n_i
  , input  logic                     start_i
  , input  tag_boot_pkg::trace_entry_t entry_i
  , input  logic                     timer_zero_i
  , output tag_boot_pkg::trace_addr_t  rd_addr_o
  , output logic                     timer_load_o
  , output tag_boot_pkg::timer_t       timer_count_o
  , output logic                     frame_load_o
  , output tag_boot_pkg::client_id_t   frame_id_o
  , output tag_boot_pkg::payload_t     frame_payload_o
  , output logic                     busy_o
  , output logic                     tag_done_o
  , output logic                     core_reset_o
);

  import tag_boot_pkg::*;

  replay_state_t       state_q;
  replay_state_t       state_d;
  trace_addr_t         addr_q;
  trace_addr_t         addr_d;
  logic [OPCODE_W-1:0] opcode;
  logic                last_entry;

  //--------------------------------------------------
  // Entry fields
  //--------------------------------------------------
  assign opcode          = entry_i[TRACE_ENTRY_W-1 -: OPCODE_W];
  assign frame_id_o      = entry_i[PAYLOAD_W +: CLIENT_ID_W];
  assign frame_payload_o = entry_i[PAYLOAD_W-1:0];

  assign rd_addr_o  = addr_q;
  assign last_entry = (addr_q == trace_addr_t'(TRACE_DEPTH - 1));

  //--------------------------------------------------
  // Next state
  //--------------------------------------------------
  always_comb begin
    state_d       = state_q;
    addr_d        = addr_q;
    timer_load_o  = 1'b0;
    timer_count_o = '0;
    frame_load_o  = 1'b0;

    case (state_q)
      ST_IDLE, ST_DONE: begin
        if (start_i) begin
          state_d = ST_FETCH;
          addr_d  = '0;
        end
      end
      ST_FETCH: begin
        state_d = ST_DECODE;
      end
      ST_DECODE: begin
        timer_load_o = 1'b1;
        case (opcode)
          OP_SEND: begin
            frame_load_o  = 1'b1;
            timer_count_o = timer_t'(FRAME_LEN);
            state_d       = ST_SEND;
          end
          OP_WAIT: begin
            timer_count_o = timer_t'(frame_payload_o) + timer_t'(1);
            state_d       = ST_WAIT;
          end
          // Reserved opcode ends the trace like a finish
          OP_FINISH, OP_RSVD: begin
            timer_count_o = timer_t'(RESET_DEPTH);
            state_d       = ST_RELEASE;
          end
        endcase
      end
      ST_SEND, ST_WAIT: begin
        if (timer_zero_i) begin
          if (last_entry) begin
            // Out of entries, behave as if a finish followed
            timer_load_o  = 1'b1;
            timer_count_o = timer_t'(RESET_DEPTH);
            state_d       = ST_RELEASE;
          end else begin
            addr_d  = addr_q + trace_addr_t'(1);
            state_d = ST_FETCH;
          end
        end
      end
      ST_RELEASE: begin
        if (timer_zero_i) begin
          state_d = ST_DONE;
        end
      end
      default: begin
        state_d = ST_IDLE;
      end
    endcase
  end

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      state_q <= ST_IDLE;
      addr_q  <= '0;
    end else begin
      state_q <= state_d;
      addr_q  <= addr_d;
    end
  end

  assign busy_o       = (state_q != ST_IDLE) && (state_q != ST_DONE);
  assign tag_done_o   = (state_q == ST_DONE);
  assign core_reset_o = (state_q != ST_DONE);

endmodule

/* replay_timer.sv */
/*
 * Down-counter for frame bits, wait cycles and the reset-release depth
 */

`timescale 1ns/10ps

module replay_timer (
  input  logic                 clk_i
  , input  logic               arst_n_i
  , input  logic               load_i
  , input  tag_boot_pkg::timer_t count_i
  , output logic               zero_o
);

  import tag_boot_pkg::*;

  timer_t cnt_q;
  logic   run_q;

  // Last cycle of the loaded interval; a load of 0 wraps to a full 256
  assign zero_o = run_q && (cnt_q == timer_t'(1));

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      cnt_q <= '0;
      run_q <= 1'b0;
    end else if (load_i) begin
      cnt_q <= count_i;
      run_q <= 1'b1;
    end else if (run_q) begin
      cnt_q <= cnt_q - timer_t'(1);
      if (zero_o) begin
        run_q <= 1'b0;
      end
    end
  end

endmodule

/* tag_trace_rom.sv */
/*
 * Writable trace memory, one write port and a registered read port
 */

`timescale 1ns/10ps

module tag_trace_rom (
  input  logic                       clk_i
  , input  logic                     we_i
  , input  tag_boot_pkg::trace_addr_t  waddr_i
  , input  tag_boot_pkg::trace_entry_t wdata_i
  , input  tag_boot_pkg::trace_addr_t  raddr_i
  , output tag_boot_pkg::trace_entry_t rdata_o
);

  import tag_boot_pkg::*;

  trace_entry_t mem_q [TRACE_DEPTH];

  // Loaded by the testbench before the first start
  always_ff @(posedge clk_i) begin
    if (we_i) begin
      mem_q[waddr_i] <= wdata_i;
    end
  end

  // Entry shows up the cycle after the address
  always_ff @(posedge clk_i) begin
    rdata_o <= mem_q[raddr_i];
  end

endmodule

/* tag_boot_pkg.sv */
/*
 * Tag boot widths, opcodes, vector types and the replay state encoding
 */

package tag_boot_pkg;

  //--------------------------------------------------
  // Client and trace sizes
  //--------------------------------------------------
  localparam int unsigned NUM_CLIENTS   = 4;
  localparam int unsigned CLIENT_ID_W   = 2;
  localparam int unsigned PAYLOAD_W     = 8;
  localparam int unsigned OPCODE_W      = 2;
  localparam int unsigned TRACE_DEPTH   = 16;
  localparam int unsigned TRACE_ADDR_W  = 4;
  localparam int unsigned TRACE_ENTRY_W = OPCODE_W + CLIENT_ID_W + PAYLOAD_W;

  // Start bit, then id, then payload
  localparam int unsigned FRAME_LEN   = 1 + CLIENT_ID_W + PAYLOAD_W;
  localparam int unsigned BIT_CNT_W   = $clog2(FRAME_LEN);
  localparam int unsigned RESET_DEPTH = 3;
  localparam int unsigned TIMER_W     = 8;

  // Trace opcodes
  localparam logic [OPCODE_W-1:0] OP_SEND   = 2'd0;
  localparam logic [OPCODE_W-1:0] OP_WAIT   = 2'd1;
  localparam logic [OPCODE_W-1:0] OP_FINISH = 2'd2;
  localparam logic [OPCODE_W-1:0] OP_RSVD   = 2'd3;

  typedef logic [CLIENT_ID_W-1:0]   client_id_t;
  typedef logic [PAYLOAD_W-1:0]     payload_t;
  typedef logic [TRACE_ADDR_W-1:0]  trace_addr_t;
  typedef logic [TRACE_ENTRY_W-1:0] trace_entry_t;
  typedef logic [TIMER_W-1:0]       timer_t;

  typedef enum logic [2:0] {
    ST_IDLE,
    ST_FETCH,
    ST_DECODE,
    ST_SEND,
    ST_WAIT,
    ST_RELEASE,
    ST_DONE
  } replay_state_t;

endpackage
